// ==== common/ss_pkg.sv ====
`default_nettype none

package ss_pkg;

    localparam int fetch_width  = 2;
    localparam int ssit_idx_w   = 6;
    localparam int ssid_w       = 4;
    localparam int rob_idx_w    = 7;                    // Top bit is the wrap flag.
    localparam int pc_w         = 32;
    localparam int ssit_entries = 1 << ssit_idx_w;
    localparam int lfst_entries = 1 << ssid_w;

    typedef logic [ssit_idx_w-1:0] ssit_idx_t;
    typedef logic [ssid_w-1:0]     ssid_t;
    typedef logic [rob_idx_w-1:0]  rob_idx_t;
    typedef logic [pc_w-1:0]       pc_t;

    typedef struct packed {
        logic  valid;
        ssid_t ssid;
    } ssit_entry_t;

    typedef struct packed {
        logic     valid;
        logic     is_load;
        logic     is_store;
        pc_t      pc;
        rob_idx_t rob_idx;
    } fetch_slot_t;

    typedef fetch_slot_t [fetch_width-1:0] fetch_group_t;

    typedef struct packed {
        pc_t load_pc;
        pc_t store_pc;
    } train_req_t;

    typedef struct packed {
        logic     valid;
        ssid_t    ssid;
        rob_idx_t rob_idx;
    } store_finish_t;

    typedef struct packed {
        logic     valid;
        logic     has_dep;
        rob_idx_t dep_rob_idx;
    } dep_slot_t;

    typedef dep_slot_t [fetch_width-1:0] dep_result_t;

    typedef struct packed {
        logic     valid;
        ssid_t    ssid;
        rob_idx_t rob_idx;
    } lfst_wslot_t;

    typedef lfst_wslot_t [fetch_width-1:0] lfst_write_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } lfst_entry_t;

    // Folds two 6-bit fields of the word address together.
    function automatic ssit_idx_t ssit_hash(input pc_t pc);
        return pc[7:2] ^ pc[13:8];
    endfunction

endpackage

`default_nettype wire

// ==== store_set/ssit_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module ssit_ram import ss_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  ssit_idx_t   [1:0]     raddr,
    output ssit_entry_t [1:0]     rdata,
    input  logic        [1:0]     we,
    input  ssit_idx_t   [1:0]     waddr,
    input  ssit_entry_t [1:0]     wdata,
    input  logic                  clear
);

    logic [ssit_entries-1:0] valid_q;
    ssid_t                   ssid_mem [ssit_entries];

    // Valid bits live apart from the ids so that one edge can clear them all.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (clear) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (we[i]) begin
                    valid_q[waddr[i]] <= wdata[i].valid;    // Port 1 last, so it wins.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (we[i]) begin
                ssid_mem[waddr[i]] <= wdata[i].ssid;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            rdata[i].valid <= valid_q[raddr[i]] & ~clear;   // Clearing table reads empty.
            rdata[i].ssid  <= ssid_mem[raddr[i]];
        end
    end

    // The controller holds back training writes in the cycle the table is wiped.
    a_clear_no_write: assert property (
        @(posedge clk) disable iff (!rst)
        clear |-> (we == 2'b00)
    ) else $error("ssit_ram: clear and write in the same cycle");

endmodule

`default_nettype wire

// ==== store_set/ssit_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module ssit_ctrl import ss_pkg::*; #(
    parameter int CLEAR_WIDTH = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_valid,
    input  fetch_group_t                  fetch,
    input  logic                          train_valid,
    input  train_req_t                    train,
    output ssit_entry_t [fetch_width-1:0] lookup,
    output logic                          cleared
);

    ssit_idx_t   [1:0]        raddr;
    ssit_entry_t [1:0]        rdata;
    ssit_idx_t   [1:0]        waddr_q;
    ssit_entry_t [1:0]        wdata;
    logic        [1:0]        wmask;
    logic        [1:0]        we;
    logic                     train_q;
    logic                     train_fire;
    logic                     found;
    logic                     clear_q;
    ssid_t                    new_ssid;
    ssid_t                    ssid_cnt;
    logic [CLEAR_WIDTH-1:0]   clr_cnt;

    // Port 0 carries the load, port 1 the store.
    always_comb begin
        if (train_valid) begin
            raddr[0] = ssit_hash(train.load_pc);
            raddr[1] = ssit_hash(train.store_pc);
        end else begin
            for (int i = 0; i < fetch_width; i++) begin
                raddr[i] = ssit_hash(fetch[i].pc);
            end
        end
    end

    assign train_fire = train_q & ~clear_q;            // Dropped while the table is wiped.
    assign found      = rdata[0].valid | rdata[1].valid;

    always_comb begin
        case ({rdata[1].valid, rdata[0].valid})
            2'b00: begin
                wmask    = 2'b11;                      // Fresh set for both.
                new_ssid = ssid_cnt;
            end
            2'b01: begin
                wmask    = 2'b10;                      // Store joins the load's set.
                new_ssid = rdata[0].ssid;
            end
            2'b10: begin
                wmask    = 2'b01;
                new_ssid = rdata[1].ssid;
            end
            default: begin
                wmask    = 2'b11;
                new_ssid = (rdata[0].ssid < rdata[1].ssid) ? rdata[0].ssid : rdata[1].ssid;
            end
        endcase
    end

    assign we       = {2{train_fire}} & wmask;
    assign wdata[0] = '{valid: 1'b1, ssid: new_ssid};
    assign wdata[1] = '{valid: 1'b1, ssid: new_ssid};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            train_q  <= 1'b0;
            clear_q  <= 1'b0;
            ssid_cnt <= '0;
            clr_cnt  <= '0;
        end else begin
            train_q <= train_valid;
            clear_q <= train_fire & found & (&clr_cnt);
            if (train_fire & ~found) begin
                ssid_cnt <= ssid_cnt + 1'b1;
            end
            if (train_fire & found) begin
                clr_cnt <= clr_cnt + 1'b1;             // Wraps at the end of an interval.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (train_valid) begin
            waddr_q <= raddr;
        end
    end

    ssit_ram u_ssit_ram (
        .clk   (clk),
        .rst   (rst),
        .raddr (raddr),
        .rdata (rdata),
        .we    (we),
        .waddr (waddr_q),
        .wdata (wdata),
        .clear (clear_q)
    );

    assign lookup  = rdata;
    assign cleared = clear_q;

    a_no_fetch_train: assert property (
        @(posedge clk) disable iff (!rst)
        !(fetch_valid && train_valid)
    ) else $error("ssit_ctrl: fetch and training in the same cycle");

endmodule

`default_nettype wire

// ==== store_set/lfst.sv ====
`timescale 1ns/10ps
`default_nettype none

module lfst import ss_pkg::*; #(
    parameter int STORE_PORTS = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  lfst_write_t                     wr,
    input  ssid_t         [fetch_width-1:0] raddr,
    output lfst_entry_t   [fetch_width-1:0] rdata,
    input  store_finish_t [STORE_PORTS-1:0] finish,
    input  logic                            redirect
);

    logic [lfst_entries-1:0] valid_q;
    logic [lfst_entries-1:0] wr_mask;
    logic [lfst_entries-1:0] fin_mask;
    rob_idx_t                rob_q [lfst_entries];

    always_comb begin
        wr_mask = '0;
        for (int i = 0; i < fetch_width; i++) begin
            if (wr[i].valid) begin
                wr_mask[wr[i].ssid] = 1'b1;
            end
        end
    end

    // A finish only hits if its store is still the youngest of the set.
    always_comb begin
        fin_mask = '0;
        for (int p = 0; p < STORE_PORTS; p++) begin
            if (finish[p].valid && valid_q[finish[p].ssid] &&
                rob_q[finish[p].ssid] == finish[p].rob_idx) begin
                fin_mask[finish[p].ssid] = 1'b1;
            end
        end
    end

    // Reads see finishes of the same cycle but not writes or a redirect.
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            rdata[i].valid   = valid_q[raddr[i]] & ~fin_mask[raddr[i]];
            rdata[i].rob_idx = rob_q[raddr[i]];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (redirect) begin
            valid_q <= '0;                                  // Beats a dispatch write.
        end else begin
            valid_q <= (valid_q & ~fin_mask) | wr_mask;     // Write beats a finish.
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (wr[i].valid) begin
                rob_q[wr[i].ssid] <= wr[i].rob_idx;         // Slot 1 is younger.
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dispatch_link.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch_link import ss_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_valid,
    input  fetch_group_t                  fetch,
    input  ssit_entry_t [fetch_width-1:0] lookup,
    output lfst_write_t                   lfst_wr,
    output ssid_t       [fetch_width-1:0] lfst_raddr,
    input  lfst_entry_t [fetch_width-1:0] lfst_rdata,
    output logic                          dep_valid,
    output dep_result_t                   dep
);

    logic                   s1_valid;
    fetch_group_t           s1_group;
    logic [fetch_width-1:0] is_ld;
    logic [fetch_width-1:0] is_st;
    logic                   fwd;
    dep_result_t            dep_next;

    // Group waits here while the SSIT is read.
    always_ff @(posedge clk) begin
        s1_group <= fetch;
        dep      <= dep_next;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid  <= 1'b0;
            dep_valid <= 1'b0;
        end else begin
            s1_valid  <= fetch_valid;
            dep_valid <= s1_valid;
        end
    end

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            is_ld[i] = s1_valid & s1_group[i].valid & s1_group[i].is_load & lookup[i].valid;
            is_st[i] = s1_valid & s1_group[i].valid & s1_group[i].is_store & lookup[i].valid;
            lfst_wr[i].valid   = is_st[i];
            lfst_wr[i].ssid    = lookup[i].ssid;
            lfst_wr[i].rob_idx = s1_group[i].rob_idx;
            lfst_raddr[i]      = lookup[i].ssid;
        end
    end

    // Slot 0 store is still in flight to the LFST, so pass it across directly.
    assign fwd = is_st[0] & is_ld[1] & (lookup[0].ssid == lookup[1].ssid);

    always_comb begin
        dep_next[0].valid       = s1_valid & s1_group[0].valid;
        dep_next[0].has_dep     = is_ld[0] & lfst_rdata[0].valid;
        dep_next[0].dep_rob_idx = lfst_rdata[0].rob_idx;
        dep_next[1].valid       = s1_valid & s1_group[1].valid;
        dep_next[1].has_dep     = is_ld[1] & (fwd | lfst_rdata[1].valid);
        dep_next[1].dep_rob_idx = fwd ? s1_group[0].rob_idx : lfst_rdata[1].rob_idx;
    end

endmodule

`default_nettype wire

// ==== hdl/store_set_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module store_set_top import ss_pkg::*; #(
    parameter int CLEAR_WIDTH = 3,
    parameter int STORE_PORTS = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fetch_valid,
    input  fetch_group_t                    fetch,
    input  logic                            train_valid,
    input  train_req_t                      train,
    input  store_finish_t [STORE_PORTS-1:0] finish,
    input  logic                            redirect,
    output logic                            dep_valid,
    output dep_result_t                     dep,
    output logic                            ssit_cleared
);

    ssit_entry_t [fetch_width-1:0] lookup;
    lfst_write_t                   lfst_wr;
    ssid_t       [fetch_width-1:0] lfst_raddr;
    lfst_entry_t [fetch_width-1:0] lfst_rdata;

    ssit_ctrl #(
        .CLEAR_WIDTH (CLEAR_WIDTH)
    ) u_ssit_ctrl (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .train_valid (train_valid),
        .train       (train),
        .lookup      (lookup),
        .cleared     (ssit_cleared)
    );

    dispatch_link u_dispatch_link (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .lookup      (lookup),
        .lfst_wr     (lfst_wr),
        .lfst_raddr  (lfst_raddr),
        .lfst_rdata  (lfst_rdata),
        .dep_valid   (dep_valid),
        .dep         (dep)
    );

    lfst #(
        .STORE_PORTS (STORE_PORTS)
    ) u_lfst (
        .clk      (clk),
        .rst      (rst),
        .wr       (lfst_wr),
        .raddr    (lfst_raddr),
        .rdata    (lfst_rdata),
        .finish   (finish),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_store_set.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_store_set import ss_pkg::*; ();

    localparam int clear_width = 3;
    localparam int rand_groups = 24;
    localparam int cycle_limit = 2 * (2 + 45 * 3 + rand_groups + 8);   // About 45 ops of 3 cycles.

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid;
    fetch_group_t          fetch;
    logic                  train_valid;
    train_req_t            train;
    store_finish_t [1:0]   finish;
    logic                  redirect;
    logic                  dep_valid;
    dep_result_t           dep;
    logic                  ssit_cleared;

    logic                  cur_exp_valid, exp_valid_q1, exp_valid_q2;
    dep_result_t           cur_exp_dep, exp_dep_q1, exp_dep_q2;
    logic                  cur_exp_clr, exp_clr_q1, exp_clr_q2;
    logic                  m_ssit_valid [ssit_entries];
    ssid_t                 m_ssit_ssid [ssit_entries];
    logic                  m_lfst_valid [lfst_entries];
    rob_idx_t              m_lfst_rob [lfst_entries];
    ssid_t                 m_next_ssid;
    logic [clear_width-1:0] m_clr_cnt;
    pc_t                   pc_tab [64];
    logic [31:0]           lcg_state;
    int                    errors, checks, cycles;
    string                 test_name;
    rob_idx_t              rob_a, rob_b;

    store_set_top DUT (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch(fetch),
        .train_valid(train_valid), .train(train), .finish(finish), .redirect(redirect),
        .dep_valid(dep_valid), .dep(dep), .ssit_cleared(ssit_cleared)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rob_idx_t random_rob();
        logic [31:0] r;
        r = lcg_next();
        return r[22:16];
    endfunction

    // Random upper bits with the hash landing on k.
    function automatic pc_t make_pc(input int k);
        logic [31:0] r;
        r = lcg_next();
        return {r[31:14], 6'd0, k[5:0], 2'b00};
    endfunction

    function automatic fetch_slot_t load_slot(input int k, input rob_idx_t rob);
        return '{valid: 1'b1, is_load: 1'b1, is_store: 1'b0, pc: pc_tab[k], rob_idx: rob};
    endfunction

    function automatic fetch_slot_t store_slot(input int k, input rob_idx_t rob);
        return '{valid: 1'b1, is_load: 1'b0, is_store: 1'b1, pc: pc_tab[k], rob_idx: rob};
    endfunction

    function automatic fetch_slot_t random_slot();
        logic [31:0] r;
        int          k;
        r = lcg_next();
        case (r[10:8])
            3'd0: k = 10;
            3'd1: k = 11;
            3'd2: k = 12;
            3'd3: k = 20;
            3'd4: k = 21;
            default: k = 40 + r[13:11];                     // Never trained.
        endcase
        return r[2] ? load_slot(k, r[22:16]) : store_slot(k, r[22:16]);
    endfunction

    function automatic logic dep_matches(input dep_result_t act, input dep_result_t want);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < fetch_width; i++) begin
            if (act[i].valid !== want[i].valid || act[i].has_dep !== want[i].has_dep) ok = 1'b0;
            if (want[i].has_dep && act[i].dep_rob_idx !== want[i].dep_rob_idx) ok = 1'b0;
        end
        return ok;
    endfunction

    function automatic void report_mismatch(input string what, input logic [31:0] want,
                                            input logic [31:0] act);
        errors++;
        $display("[ERROR] %s: %s expected %h actual %h", test_name, what, want, act);
    endfunction

    task automatic clear_inputs();
        fetch_valid   = 1'b0;
        fetch         = '0;
        train_valid   = 1'b0;
        train         = '0;
        finish        = '0;
        redirect      = 1'b0;
        cur_exp_valid = 1'b0;
        cur_exp_dep   = '0;
        cur_exp_clr   = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    task automatic fetch_group(input fetch_slot_t s0, input fetch_slot_t s1);
        fetch_slot_t s [fetch_width];
        ssit_entry_t e [fetch_width];
        dep_result_t want;
        @(negedge clk);
        clear_inputs();
        s[0] = s0;
        s[1] = s1;
        want = '0;
        for (int i = 0; i < fetch_width; i++) begin
            e[i].valid = m_ssit_valid[ssit_hash(s[i].pc)];
            e[i].ssid  = m_ssit_ssid[ssit_hash(s[i].pc)];
            want[i].valid = s[i].valid;
            if (s[i].valid && s[i].is_load && e[i].valid && m_lfst_valid[e[i].ssid]) begin
                want[i].has_dep     = 1'b1;
                want[i].dep_rob_idx = m_lfst_rob[e[i].ssid];
            end
        end
        if (s[0].valid && s[0].is_store && e[0].valid && s[1].valid && s[1].is_load &&
            e[1].valid && e[0].ssid == e[1].ssid) begin
            want[1].has_dep     = 1'b1;                     // Older store of the same group.
            want[1].dep_rob_idx = s[0].rob_idx;
        end
        for (int i = 0; i < fetch_width; i++) begin
            if (s[i].valid && s[i].is_store && e[i].valid) begin
                m_lfst_valid[e[i].ssid] = 1'b1;
                m_lfst_rob[e[i].ssid]   = s[i].rob_idx;
            end
        end
        fetch_valid   = 1'b1;
        fetch[0]      = s0;
        fetch[1]      = s1;
        cur_exp_valid = 1'b1;
        cur_exp_dep   = want;
    endtask

    task automatic train_pair(input int load_k, input int store_k);
        ssit_idx_t li, si;
        logic      lv, sv;
        ssid_t     id;
        @(negedge clk);
        clear_inputs();
        train_valid = 1'b1;
        train       = '{load_pc: pc_tab[load_k], store_pc: pc_tab[store_k]};
        li = ssit_hash(pc_tab[load_k]);
        si = ssit_hash(pc_tab[store_k]);
        lv = m_ssit_valid[li];
        sv = m_ssit_valid[si];
        if (!lv && !sv) begin
            id = m_next_ssid;
            m_next_ssid++;
        end else if (lv && !sv) begin
            id = m_ssit_ssid[li];
        end else if (!lv && sv) begin
            id = m_ssit_ssid[si];
        end else begin
            id = (m_ssit_ssid[li] < m_ssit_ssid[si]) ? m_ssit_ssid[li] : m_ssit_ssid[si];
        end
        m_ssit_valid[li] = 1'b1;
        m_ssit_ssid[li]  = id;
        m_ssit_valid[si] = 1'b1;
        m_ssit_ssid[si]  = id;
        if (lv || sv) begin
            if (m_clr_cnt == {clear_width{1'b1}}) begin
                cur_exp_clr = 1'b1;
                foreach (m_ssit_valid[i]) m_ssit_valid[i] = 1'b0;
            end
            m_clr_cnt++;
        end
        idle(2);                                            // Write lands and the table settles.
    endtask

    task automatic finish_store(input int port, input int store_k, input rob_idx_t rob);
        ssid_t id;
        idle(1);
        @(negedge clk);
        clear_inputs();
        id = m_ssit_ssid[ssit_hash(pc_tab[store_k])];
        finish[port] = '{valid: 1'b1, ssid: id, rob_idx: rob};
        if (m_lfst_valid[id] && m_lfst_rob[id] == rob) m_lfst_valid[id] = 1'b0;
    endtask

    task automatic redirect_all();
        idle(1);
        @(negedge clk);
        clear_inputs();
        redirect = 1'b1;
        foreach (m_lfst_valid[i]) m_lfst_valid[i] = 1'b0;
    endtask

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            exp_valid_q1 <= 1'b0;
            exp_valid_q2 <= 1'b0;
            exp_dep_q1   <= '0;
            exp_dep_q2   <= '0;
            exp_clr_q1   <= 1'b0;
            exp_clr_q2   <= 1'b0;
        end else begin
            exp_valid_q1 <= cur_exp_valid;
            exp_valid_q2 <= exp_valid_q1;
            exp_dep_q1   <= cur_exp_dep;
            exp_dep_q2   <= exp_dep_q1;
            exp_clr_q1   <= cur_exp_clr;
            exp_clr_q2   <= exp_clr_q1;
            if (exp_valid_q2) checks++;
        end
    end

    a_dep_valid: assert property (@(posedge clk) disable iff (!rst) dep_valid == exp_valid_q2)
        else report_mismatch("dep_valid", $sampled(exp_valid_q2), $sampled(dep_valid));
    a_dep: assert property (@(posedge clk) disable iff (!rst)
        exp_valid_q2 |-> dep_matches(dep, exp_dep_q2))
        else report_mismatch("dep", $sampled(exp_dep_q2), $sampled(dep));
    a_cleared: assert property (@(posedge clk) disable iff (!rst) ssit_cleared == exp_clr_q2)
        else report_mismatch("ssit_cleared", $sampled(exp_clr_q2), $sampled(ssit_cleared));

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        lcg_state   = 32'h9c9b_e96c;
        errors      = 0;
        checks      = 0;
        m_next_ssid = '0;
        m_clr_cnt   = '0;
        foreach (m_ssit_valid[i]) m_ssit_valid[i] = 1'b0;
        foreach (m_lfst_valid[i]) m_lfst_valid[i] = 1'b0;
        foreach (pc_tab[k]) pc_tab[k] = make_pc(k);
        test_name = "reset";
        clear_inputs();
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_name = "untrained";
        fetch_group(load_slot(1, random_rob()), store_slot(2, random_rob()));
        fetch_group(store_slot(3, random_rob()), load_slot(3, random_rob()));
        fetch_group(load_slot(4, random_rob()), '0);
        idle(2);

        test_name = "trained_pair";
        train_pair(10, 11);
        rob_a = random_rob();
        fetch_group(store_slot(11, rob_a), '0);
        fetch_group(load_slot(10, random_rob()), '0);
        rob_b = random_rob();
        fetch_group('0, store_slot(11, rob_b));
        fetch_group(load_slot(4, random_rob()), load_slot(10, random_rob()));

        test_name = "merge";
        train_pair(12, 11);                                 // Load joins the store's set.
        fetch_group(store_slot(11, random_rob()), '0);
        fetch_group(load_slot(12, random_rob()), '0);
        train_pair(20, 21);
        train_pair(12, 21);                                 // Two sets merge into the smaller id.
        fetch_group(store_slot(21, random_rob()), '0);
        fetch_group(load_slot(10, random_rob()), load_slot(20, random_rob()));

        test_name = "forward";
        fetch_group(store_slot(11, random_rob()), load_slot(10, random_rob()));
        fetch_group(store_slot(21, random_rob()), load_slot(12, random_rob()));

        test_name = "finish";
        rob_a = random_rob();
        fetch_group(store_slot(11, rob_a), '0);
        finish_store(0, 11, rob_a ^ 7'h01);
        fetch_group(load_slot(10, random_rob()), '0);
        finish_store(1, 11, rob_a);
        fetch_group(load_slot(10, random_rob()), '0);

        test_name = "redirect";
        fetch_group(store_slot(11, random_rob()), store_slot(20, random_rob()));
        redirect_all();
        fetch_group(load_slot(10, random_rob()), load_slot(20, random_rob()));

        test_name = "random_groups";
        for (int n = 0; n < rand_groups; n++) begin
            fetch_group(random_slot(), random_slot());
        end
        idle(2);

        test_name = "periodic_clear";
        for (int k = 0; k < 6; k++) begin
            train_pair(30 + k, 11);
        end
        fetch_group(store_slot(11, random_rob()), '0);
        fetch_group(load_slot(10, random_rob()), load_slot(12, random_rob()));
        idle(4);

        $display("Checked %0d results, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/ss_pkg.sv
store_set/ssit_ram.sv
store_set/ssit_ctrl.sv
store_set/lfst.sv
hdl/dispatch_link.sv
hdl/store_set_top.sv
testbench/tb_store_set.sv
